// File: include/idma_lite_macros.svh
// iDMA AXI4-Lite transport layer
// global widths and reorder buffer depth, shared by RTL and testbench

`ifndef IDMA_LITE_MACROS_SVH
`define IDMA_LITE_MACROS_SVH

// bus data width in bits
`define IDMA_LITE_DATA_WIDTH 32

// byte lanes per beat
`define IDMA_LITE_STRB_WIDTH 4

// bits needed to index a byte lane
`define IDMA_LITE_IDX_WIDTH 2

// entries per byte-lane FIFO
// 2 is the minimum, 3 keeps misaligned streams moving without bubbles
`define IDMA_LITE_BUFFER_DEPTH 3

`endif

// File: design/idma_lite_pkg.sv
// iDMA AXI4-Lite transport layer types
// plain vector typedefs for beats, strobes, bytes, lane indices and responses

`include "idma_lite_macros.svh"

package idma_lite_pkg;

    // one bus beat
    typedef logic [`IDMA_LITE_DATA_WIDTH-1:0] data_t;

    // byte-lane mask or write strobe
    typedef logic [`IDMA_LITE_STRB_WIDTH-1:0] strb_t;

    // single byte lane
    typedef logic [7:0] byte_t;

    // byte offset, tailer or shift amount within a beat
    typedef logic [`IDMA_LITE_IDX_WIDTH-1:0] lane_idx_t;

    // AXI response code (OKAY, EXOKAY, SLVERR, DECERR)
    typedef logic [1:0] resp_t;

endpackage

// File: design/idma_lite_byte_fifo.sv
// single byte-lane FIFO
// circular buffer with fill count, no fall-through, ready low only when full

`timescale 1ns/1ps
`include "idma_lite_macros.svh"

module idma_lite_byte_fifo #(
    parameter int unsigned Depth = `IDMA_LITE_BUFFER_DEPTH
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  idma_lite_pkg::byte_t data_i,
    input  logic                valid_i,
    output logic                ready_o,
    output idma_lite_pkg::byte_t data_o,
    output logic                valid_o,
    input  logic                ready_i
);

    localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntWidth = $clog2(Depth + 1);

    idma_lite_pkg::byte_t mem [Depth];
    logic [PtrWidth-1:0]  wr_ptr;
    logic [PtrWidth-1:0]  rd_ptr;
    logic [CntWidth-1:0]  count;
    logic                 push;
    logic                 pop;

    // handshakes on both sides
    assign push    = valid_i & ready_o;
    assign pop     = valid_o & ready_i;
    assign ready_o = (count != CntWidth'(Depth));
    assign valid_o = (count != '0);
    // head entry straight from the storage registers
    assign data_o  = mem[rd_ptr];

    // pointers and fill level
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PtrWidth'(Depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PtrWidth'(Depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop keeps the level
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= data_i;
        end
    end

    // the write side only offers a byte while the lane has room
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i |-> ready_o);
    // the read side only takes a byte that is there
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ready_i |-> valid_o);

endmodule

// File: design/idma_lite_byte_buffer.sv
// reorder buffer of the transport layer
// one independent byte FIFO per strobe lane, lanes drain at their own pace

`timescale 1ns/1ps
`include "idma_lite_macros.svh"

module idma_lite_byte_buffer (
    input  logic                                              clk_i,
    input  logic                                              rst_n_i,
    input  idma_lite_pkg::byte_t [`IDMA_LITE_STRB_WIDTH-1:0] data_i,
    input  idma_lite_pkg::strb_t                              valid_i,
    output idma_lite_pkg::strb_t                              ready_o,
    output idma_lite_pkg::byte_t [`IDMA_LITE_STRB_WIDTH-1:0] data_o,
    output idma_lite_pkg::strb_t                              valid_o,
    input  idma_lite_pkg::strb_t                              ready_i,
    output logic                                              busy_o
);

    // one FIFO per lane, no coupling between lanes
    for (genvar i = 0; i < `IDMA_LITE_STRB_WIDTH; i++) begin : gen_lane
        idma_lite_byte_fifo #(
            .Depth ( `IDMA_LITE_BUFFER_DEPTH )
        ) i_lane_fifo (
            .clk_i   ( clk_i      ),
            .rst_n_i ( rst_n_i    ),
            .data_i  ( data_i[i]  ),
            .valid_i ( valid_i[i] ),
            .ready_o ( ready_o[i] ),
            .data_o  ( data_o[i]  ),
            .valid_o ( valid_o[i] ),
            .ready_i ( ready_i[i] )
        );
    end

    // any lane still holding data keeps the buffer busy
    assign busy_o = |valid_o;

    // an idle buffer stays idle unless some lane gets pushed
    a_clean_holds: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !busy_o && (valid_i == '0) |=> !busy_o && (valid_o == '0));

endmodule

// File: design/idma_lite_read_aligner.sv
// read side of the transport layer
// masks the R beat by offset and tailer, rotates it into write alignment
// and pushes the valid lanes into the reorder buffer

`timescale 1ns/1ps
`include "idma_lite_macros.svh"

module idma_lite_read_aligner (
    input  logic                                              clk_i,
    input  logic                                              rst_n_i,
    input  idma_lite_pkg::lane_idx_t                          r_offset_i,
    input  idma_lite_pkg::lane_idx_t                          r_tailer_i,
    input  idma_lite_pkg::lane_idx_t                          r_shift_i,
    input  logic                                              r_dp_valid_i,
    output logic                                              r_dp_ready_o,
    input  logic                                              r_dp_ready_i,
    output logic                                              r_dp_valid_o,
    output idma_lite_pkg::resp_t                              r_dp_rsp_resp_o,
    input  idma_lite_pkg::data_t                              m_r_data_i,
    input  idma_lite_pkg::resp_t                              m_r_resp_i,
    input  logic                                              m_r_valid_i,
    output logic                                              m_r_ready_o,
    output idma_lite_pkg::byte_t [`IDMA_LITE_STRB_WIDTH-1:0] buf_data_o,
    output idma_lite_pkg::strb_t                              buf_valid_o,
    input  idma_lite_pkg::strb_t                              buf_ready_i,
    output logic                                              r_dp_busy_o
);

    idma_lite_pkg::strb_t                     rd_mask;
    idma_lite_pkg::strb_t                     rot_mask;
    logic [2*`IDMA_LITE_DATA_WIDTH-1:0]       data_dbl;
    logic [2*`IDMA_LITE_STRB_WIDTH-1:0]       mask_dbl;
    logic                                     in_ready;
    logic                                     push;

    // ------------------------------------------------------------------------
    // read mask
    // ------------------------------------------------------------------------
    always_comb begin
        // lanes at or above the offset
        rd_mask = {`IDMA_LITE_STRB_WIDTH{1'b1}} << r_offset_i;
        // a nonzero tailer cuts off the top lanes
        if (r_tailer_i != '0) begin
            rd_mask = rd_mask & ({`IDMA_LITE_STRB_WIDTH{1'b1}} >>
                                 (`IDMA_LITE_STRB_WIDTH - r_tailer_i));
        end
    end

    // ------------------------------------------------------------------------
    // barrel shifter
    // ------------------------------------------------------------------------
    // doubled word shifted down, lane j takes lane (j + shift) mod 4
    assign data_dbl   = {m_r_data_i, m_r_data_i} >> (r_shift_i * 8);
    assign mask_dbl   = {rd_mask, rd_mask} >> r_shift_i;
    assign buf_data_o = data_dbl[`IDMA_LITE_DATA_WIDTH-1:0];
    assign rot_mask   = mask_dbl[`IDMA_LITE_STRB_WIDTH-1:0];

    // ------------------------------------------------------------------------
    // R channel control
    // ------------------------------------------------------------------------
    // all lanes we need must have room, unused lanes don't matter
    assign in_ready    = &(buf_ready_i | ~rot_mask);
    // response side has to be able to take the beat too
    assign m_r_ready_o = in_ready & r_dp_ready_i;
    assign push        = m_r_valid_i & m_r_ready_o;
    assign buf_valid_o = push ? rot_mask : '0;

    // request done in the same cycle the beat is taken
    assign r_dp_ready_o    = r_dp_valid_i & push;
    // only error responses go up to the datapath
    assign r_dp_valid_o    = push & (|m_r_resp_i);
    assign r_dp_rsp_resp_o = m_r_resp_i;

    assign r_dp_busy_o = r_dp_valid_i | r_dp_ready_o;

    // a stalled R beat keeps its data and response until the buffer takes it
    a_r_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        m_r_valid_i && !m_r_ready_o |=>
        m_r_valid_i && $stable(m_r_data_i) && $stable(m_r_resp_i));

endmodule

// File: design/idma_lite_write_assembler.sv
// write side of the transport layer
// waits until the buffer holds every lane of the write mask, then drives
// one masked W beat and pops those lanes; B goes back to the datapath

`timescale 1ns/1ps
`include "idma_lite_macros.svh"

module idma_lite_write_assembler (
    input  logic                                              clk_i,
    input  logic                                              rst_n_i,
    input  idma_lite_pkg::lane_idx_t                          w_offset_i,
    input  idma_lite_pkg::lane_idx_t                          w_tailer_i,
    input  logic                                              w_dp_valid_i,
    output logic                                              w_dp_ready_o,
    output logic                                              w_dp_valid_o,
    input  logic                                              w_dp_ready_i,
    output idma_lite_pkg::resp_t                              w_dp_rsp_resp_o,
    input  logic                                              dp_poison_i,
    input  idma_lite_pkg::byte_t [`IDMA_LITE_STRB_WIDTH-1:0] buf_data_i,
    input  idma_lite_pkg::strb_t                              buf_valid_i,
    output idma_lite_pkg::strb_t                              buf_ready_o,
    output idma_lite_pkg::data_t                              m_w_data_o,
    output idma_lite_pkg::strb_t                              m_w_strb_o,
    output logic                                              m_w_valid_o,
    input  logic                                              m_w_ready_i,
    input  idma_lite_pkg::resp_t                              m_b_resp_i,
    input  logic                                              m_b_valid_i,
    output logic                                              m_b_ready_o,
    output logic                                              w_dp_busy_o
);

    idma_lite_pkg::strb_t w_mask;
    logic                 ready_to_write;
    logic                 write_happening;

    // ------------------------------------------------------------------------
    // write mask, doubles as the strobe
    // ------------------------------------------------------------------------
    always_comb begin
        w_mask = {`IDMA_LITE_STRB_WIDTH{1'b1}} << w_offset_i;
        if (w_tailer_i != '0) begin
            w_mask = w_mask & ({`IDMA_LITE_STRB_WIDTH{1'b1}} >>
                               (`IDMA_LITE_STRB_WIDTH - w_tailer_i));
        end
    end

    // ------------------------------------------------------------------------
    // W channel
    // ------------------------------------------------------------------------
    // every lane the strobe needs is present, and the buffer isn't empty
    assign ready_to_write  = ((buf_valid_i & w_mask) == w_mask) & (buf_valid_i != '0);
    assign write_happening = ready_to_write & m_w_ready_i;
    assign m_w_valid_o     = ready_to_write;
    // pop exactly the strobed lanes on the handshake
    assign buf_ready_o     = write_happening ? w_mask : '0;
    assign w_dp_ready_o    = write_happening;

    always_comb begin
        m_w_data_o = '0;
        m_w_strb_o = '0;
        // poison kills data and strobe but leaves valid alone
        if (ready_to_write && !dp_poison_i) begin
            for (int i = 0; i < `IDMA_LITE_STRB_WIDTH; i++) begin
                m_w_data_o[i*8 +: 8] = w_mask[i] ? buf_data_i[i] : 8'h00;
            end
            m_w_strb_o = w_mask;
        end
    end

    // ------------------------------------------------------------------------
    // B channel
    // ------------------------------------------------------------------------
    assign w_dp_valid_o    = m_b_valid_i;
    assign w_dp_rsp_resp_o = m_b_resp_i;
    // datapath back-pressure goes straight onto B
    assign m_b_ready_o     = w_dp_ready_i;

    assign w_dp_busy_o = w_dp_valid_i | w_dp_ready_o;

    // a stalled beat keeps valid and its data until the bus takes it
    a_w_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        m_w_valid_o && !m_w_ready_i && !dp_poison_i |=>
        m_w_valid_o && (dp_poison_i || $stable(m_w_data_o)));

endmodule

// File: design/idma_axi_lite_transport_layer.sv
// AXI4-Lite transport layer of the iDMA backend
// AR and AW pass straight to the bus, R beats are realigned through the
// byte-lane reorder buffer and leave as W beats, B goes back up

`timescale 1ns/1ps
`include "idma_lite_macros.svh"

module idma_axi_lite_transport_layer (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    // read datapath request and response
    input  idma_lite_pkg::lane_idx_t r_offset_i,
    input  idma_lite_pkg::lane_idx_t r_tailer_i,
    input  idma_lite_pkg::lane_idx_t r_shift_i,
    input  logic                     r_dp_valid_i,
    output logic                     r_dp_ready_o,
    output idma_lite_pkg::resp_t     r_dp_rsp_resp_o,
    output logic                     r_dp_valid_o,
    input  logic                     r_dp_ready_i,
    // write datapath request and response
    input  idma_lite_pkg::lane_idx_t w_offset_i,
    input  idma_lite_pkg::lane_idx_t w_tailer_i,
    input  logic                     w_dp_valid_i,
    output logic                     w_dp_ready_o,
    output idma_lite_pkg::resp_t     w_dp_rsp_resp_o,
    output logic                     w_dp_valid_o,
    input  logic                     w_dp_ready_i,
    // meta requests
    input  idma_lite_pkg::data_t     ar_addr_i,
    input  logic                     ar_valid_i,
    output logic                     ar_ready_o,
    input  idma_lite_pkg::data_t     aw_addr_i,
    input  logic                     aw_valid_i,
    output logic                     aw_ready_o,
    // AXI-Lite manager port
    output idma_lite_pkg::data_t     m_ar_addr_o,
    output logic                     m_ar_valid_o,
    input  logic                     m_ar_ready_i,
    output idma_lite_pkg::data_t     m_aw_addr_o,
    output logic                     m_aw_valid_o,
    input  logic                     m_aw_ready_i,
    input  idma_lite_pkg::data_t     m_r_data_i,
    input  idma_lite_pkg::resp_t     m_r_resp_i,
    input  logic                     m_r_valid_i,
    output logic                     m_r_ready_o,
    output idma_lite_pkg::data_t     m_w_data_o,
    output idma_lite_pkg::strb_t     m_w_strb_o,
    output logic                     m_w_valid_o,
    input  logic                     m_w_ready_i,
    input  idma_lite_pkg::resp_t     m_b_resp_i,
    input  logic                     m_b_valid_i,
    output logic                     m_b_ready_o,
    // control
    input  logic                     dp_poison_i,
    output logic                     r_dp_busy_o,
    output logic                     w_dp_busy_o,
    output logic                     buffer_busy_o
);

    // rotated read bytes going in, write-aligned bytes coming out
    idma_lite_pkg::byte_t [`IDMA_LITE_STRB_WIDTH-1:0] buf_in_data;
    idma_lite_pkg::strb_t                              buf_in_valid;
    idma_lite_pkg::strb_t                              buf_in_ready;
    idma_lite_pkg::byte_t [`IDMA_LITE_STRB_WIDTH-1:0] buf_out_data;
    idma_lite_pkg::strb_t                              buf_out_valid;
    idma_lite_pkg::strb_t                              buf_out_ready;

    // ------------------------------------------------------------------------
    // meta channels, pure feed-through
    // ------------------------------------------------------------------------
    assign m_ar_addr_o  = ar_addr_i;
    assign m_ar_valid_o = ar_valid_i;
    assign ar_ready_o   = m_ar_ready_i;
    assign m_aw_addr_o  = aw_addr_i;
    assign m_aw_valid_o = aw_valid_i;
    assign aw_ready_o   = m_aw_ready_i;

    // ------------------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------------------
    idma_lite_read_aligner i_read_aligner (
        .clk_i, .rst_n_i,
        .r_offset_i, .r_tailer_i, .r_shift_i,
        .r_dp_valid_i, .r_dp_ready_o, .r_dp_ready_i, .r_dp_valid_o, .r_dp_rsp_resp_o,
        .m_r_data_i, .m_r_resp_i, .m_r_valid_i, .m_r_ready_o,
        .buf_data_o  ( buf_in_data  ),
        .buf_valid_o ( buf_in_valid ),
        .buf_ready_i ( buf_in_ready ),
        .r_dp_busy_o
    );

    idma_lite_byte_buffer i_byte_buffer (
        .clk_i, .rst_n_i,
        .data_i  ( buf_in_data   ),
        .valid_i ( buf_in_valid  ),
        .ready_o ( buf_in_ready  ),
        .data_o  ( buf_out_data  ),
        .valid_o ( buf_out_valid ),
        .ready_i ( buf_out_ready ),
        .busy_o  ( buffer_busy_o )
    );

    idma_lite_write_assembler i_write_assembler (
        .clk_i, .rst_n_i,
        .w_offset_i, .w_tailer_i,
        .w_dp_valid_i, .w_dp_ready_o, .w_dp_valid_o, .w_dp_ready_i, .w_dp_rsp_resp_o,
        .dp_poison_i,
        .buf_data_i  ( buf_out_data  ),
        .buf_valid_i ( buf_out_valid ),
        .buf_ready_o ( buf_out_ready ),
        .m_w_data_o, .m_w_strb_o, .m_w_valid_o, .m_w_ready_i,
        .m_b_resp_i, .m_b_valid_i, .m_b_ready_o,
        .w_dp_busy_o
    );

endmodule

// File: test/tb_idma_lite_transport.sv
// testbench for the AXI4-Lite transport layer
// replays single-beat transfers from the vectors file against a bus model
// with random W stalls, random datapath back-pressure and delayed B

`timescale 1ns/1ps

module tb_idma_lite_transport;

    localparam int NumVectors = 18;
    localparam int Timeout    = 200;

    // DUT ports, same names so the instance can use .*
    logic                     clk_i;
    logic                     rst_n_i;
    idma_lite_pkg::lane_idx_t r_offset_i;
    idma_lite_pkg::lane_idx_t r_tailer_i;
    idma_lite_pkg::lane_idx_t r_shift_i;
    logic                     r_dp_valid_i;
    logic                     r_dp_ready_o;
    idma_lite_pkg::resp_t     r_dp_rsp_resp_o;
    logic                     r_dp_valid_o;
    logic                     r_dp_ready_i;
    idma_lite_pkg::lane_idx_t w_offset_i;
    idma_lite_pkg::lane_idx_t w_tailer_i;
    logic                     w_dp_valid_i;
    logic                     w_dp_ready_o;
    idma_lite_pkg::resp_t     w_dp_rsp_resp_o;
    logic                     w_dp_valid_o;
    logic                     w_dp_ready_i;
    idma_lite_pkg::data_t     ar_addr_i;
    logic                     ar_valid_i;
    logic                     ar_ready_o;
    idma_lite_pkg::data_t     aw_addr_i;
    logic                     aw_valid_i;
    logic                     aw_ready_o;
    idma_lite_pkg::data_t     m_ar_addr_o;
    logic                     m_ar_valid_o;
    logic                     m_ar_ready_i;
    idma_lite_pkg::data_t     m_aw_addr_o;
    logic                     m_aw_valid_o;
    logic                     m_aw_ready_i;
    idma_lite_pkg::data_t     m_r_data_i;
    idma_lite_pkg::resp_t     m_r_resp_i;
    logic                     m_r_valid_i;
    logic                     m_r_ready_o;
    idma_lite_pkg::data_t     m_w_data_o;
    idma_lite_pkg::strb_t     m_w_strb_o;
    logic                     m_w_valid_o;
    logic                     m_w_ready_i;
    idma_lite_pkg::resp_t     m_b_resp_i;
    logic                     m_b_valid_i;
    logic                     m_b_ready_o;
    logic                     dp_poison_i;
    logic                     r_dp_busy_o;
    logic                     w_dp_busy_o;
    logic                     buffer_busy_o;

    // one transfer per entry, see the vectors file for the field layout
    logic [99:0] vectors [NumVectors];
    logic [31:0] lfsr_state;
    int          checks;
    int          errors;
    int          timeouts;

    idma_axi_lite_transport_layer uut (.*);

    // 40 ns clock
    always #20 clk_i = ~clk_i;

    // Galois LFSR, one step per random bit
    function automatic logic next_bit();
        lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        return lfsr_state[0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic note_timeout(input string what);
        timeouts++;
        $display("ERROR: nothing happened within %0d cycles while waiting for %s",
                 Timeout, what);
    endtask

    // nothing in flight, buffer drained
    task automatic check_idle();
        check_bit("buffer_busy_o", buffer_busy_o, 1'b0);
        check_bit("r_dp_busy_o", r_dp_busy_o, 1'b0);
        check_bit("w_dp_busy_o", w_dp_busy_o, 1'b0);
        check_bit("m_w_valid_o", m_w_valid_o, 1'b0);
        check_bit("m_r_ready_o", m_r_ready_o, 1'b0);
        check_bit("r_dp_valid_o", r_dp_valid_o, 1'b0);
    endtask

    // ------------------------------------------------------------------------
    // one transfer: AR/AW, one R beat, one W beat, one B response
    // ------------------------------------------------------------------------
    task automatic run_transfer(input int idx);
        logic [99:0]          vec;
        idma_lite_pkg::resp_t rresp;
        idma_lite_pkg::data_t exp_data;
        idma_lite_pkg::strb_t exp_strb;
        idma_lite_pkg::resp_t exp_bresp;
        logic                 done;
        logic                 seen;
        logic [1:0]           delay;
        int                   cycles;

        vec       = vectors[idx];
        rresp     = vec[41:40];
        exp_data  = vec[39:8];
        exp_strb  = vec[7:4];
        exp_bresp = vec[1:0];

        // datapath requests and meta requests, bus takes AR and AW at once
        @(posedge clk_i);
        r_offset_i   <= vec[97:96];
        r_tailer_i   <= vec[93:92];
        r_shift_i    <= vec[89:88];
        w_offset_i   <= vec[85:84];
        w_tailer_i   <= vec[81:80];
        dp_poison_i  <= vec[76];
        r_dp_valid_i <= 1'b1;
        w_dp_valid_i <= 1'b1;
        ar_addr_i    <= 32'h1000_0000 + 32'(idx) * 32'd4;
        aw_addr_i    <= 32'h2000_0000 + 32'(idx) * 32'd4;
        ar_valid_i   <= 1'b1;
        aw_valid_i   <= 1'b1;
        m_ar_ready_i <= 1'b1;
        m_aw_ready_i <= 1'b1;
        @(negedge clk_i);
        check_value("m_ar_addr_o", m_ar_addr_o, ar_addr_i);
        check_bit("m_ar_valid_o", m_ar_valid_o, 1'b1);
        check_bit("ar_ready_o", ar_ready_o, 1'b1);
        check_value("m_aw_addr_o", m_aw_addr_o, aw_addr_i);
        check_bit("m_aw_valid_o", m_aw_valid_o, 1'b1);
        check_bit("aw_ready_o", aw_ready_o, 1'b1);

        // R beat, the read response side stalls at random
        @(posedge clk_i);
        ar_valid_i   <= 1'b0;
        aw_valid_i   <= 1'b0;
        m_ar_ready_i <= 1'b0;
        m_aw_ready_i <= 1'b0;
        m_r_data_i   <= vec[75:44];
        m_r_resp_i   <= rresp;
        m_r_valid_i  <= 1'b1;
        r_dp_ready_i <= next_bit();
        done = 1'b0;
        for (cycles = 0; cycles < Timeout && !done; cycles++) begin
            @(negedge clk_i);
            // buffer is empty here, so only r_dp_ready_i can hold R
            check_bit("m_r_ready_o", m_r_ready_o, r_dp_ready_i);
            check_bit("r_dp_ready_o", r_dp_ready_o, r_dp_ready_i);
            check_bit("r_dp_valid_o", r_dp_valid_o, r_dp_ready_i && (rresp != 2'b00));
            check_bit("r_dp_busy_o", r_dp_busy_o, 1'b1);
            if (r_dp_valid_o) begin
                check_value("r_dp_rsp_resp_o", 32'(r_dp_rsp_resp_o), 32'(rresp));
            end
            done = m_r_ready_o;
            @(posedge clk_i);
            if (done) begin
                m_r_valid_i  <= 1'b0;
                r_dp_valid_i <= 1'b0;
                r_dp_ready_i <= 1'b0;
            end else begin
                r_dp_ready_i <= next_bit();
            end
        end
        if (!done) begin
            note_timeout("the R handshake");
            return;
        end

        // W beat, bus stalls at random and the beat must hold still
        done = 1'b0;
        seen = 1'b0;
        for (cycles = 0; cycles < Timeout && !done; cycles++) begin
            @(negedge clk_i);
            if (seen) begin
                check_bit("m_w_valid_o", m_w_valid_o, 1'b1);
            end
            if (m_w_valid_o) begin
                seen = 1'b1;
                check_value("m_w_data_o", m_w_data_o, exp_data);
                check_value("m_w_strb_o", 32'(m_w_strb_o), 32'(exp_strb));
                check_bit("w_dp_ready_o", w_dp_ready_o, m_w_ready_i);
                done = m_w_ready_i;
            end
            check_bit("w_dp_busy_o", w_dp_busy_o, 1'b1);
            @(posedge clk_i);
            if (done) begin
                m_w_ready_i  <= 1'b0;
                w_dp_valid_i <= 1'b0;
            end else begin
                m_w_ready_i <= next_bit();
            end
        end
        if (!done) begin
            note_timeout("the W handshake");
            return;
        end

        // B after 0 to 3 idle cycles, datapath takes it at random
        delay[0] = next_bit();
        delay[1] = next_bit();
        repeat (delay) @(posedge clk_i);
        m_b_resp_i   <= exp_bresp;
        m_b_valid_i  <= 1'b1;
        w_dp_ready_i <= next_bit();
        dp_poison_i  <= 1'b0;
        done = 1'b0;
        for (cycles = 0; cycles < Timeout && !done; cycles++) begin
            @(negedge clk_i);
            check_bit("w_dp_valid_o", w_dp_valid_o, 1'b1);
            check_bit("m_b_ready_o", m_b_ready_o, w_dp_ready_i);
            check_value("w_dp_rsp_resp_o", 32'(w_dp_rsp_resp_o), 32'(exp_bresp));
            done = m_b_ready_o;
            @(posedge clk_i);
            if (done) begin
                m_b_valid_i  <= 1'b0;
                w_dp_ready_i <= 1'b0;
            end else begin
                w_dp_ready_i <= next_bit();
            end
        end
        if (!done) begin
            note_timeout("the B handshake");
            return;
        end

        @(negedge clk_i);
        check_idle();
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        clk_i        = 1'b0;
        rst_n_i      = 1'b0;
        r_offset_i   = '0;
        r_tailer_i   = '0;
        r_shift_i    = '0;
        r_dp_valid_i = 1'b0;
        r_dp_ready_i = 1'b0;
        w_offset_i   = '0;
        w_tailer_i   = '0;
        w_dp_valid_i = 1'b0;
        w_dp_ready_i = 1'b0;
        ar_addr_i    = '0;
        ar_valid_i   = 1'b0;
        aw_addr_i    = '0;
        aw_valid_i   = 1'b0;
        m_ar_ready_i = 1'b0;
        m_aw_ready_i = 1'b0;
        m_r_data_i   = '0;
        m_r_resp_i   = '0;
        m_r_valid_i  = 1'b0;
        m_w_ready_i  = 1'b0;
        m_b_resp_i   = '0;
        m_b_valid_i  = 1'b0;
        dp_poison_i  = 1'b0;
        lfsr_state   = 32'hf81a9a4a;
        checks       = 0;
        errors       = 0;
        timeouts     = 0;
        $readmemh("test/idma_lite_vectors.txt", vectors);

        // reset for 3 cycles
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_idle();

        for (int i = 0; i < NumVectors && timeouts == 0; i++) begin
            run_transfer(i);
        end

        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: test/idma_lite_vectors.txt
// roff rtail rshift _ woff wtail _ poison _ rdata _ rresp _ wdata _ wstrb _ bresp
// one hex digit per field, except the 32-bit read data and expected W data
000_00_0_A1B2C3D4_0_A1B2C3D4_F_0
000_00_0_11223344_0_11223344_F_2
131_02_0_DEADBEEF_0_0000ADBE_3_0
202_02_0_89ABCDEF_0_000089AB_3_0
022_20_0_01234567_0_45670000_C_0
033_10_0_CAFEF00D_0_FEF00D00_E_0
303_01_0_5A6B7C8D_0_0000005A_1_0
000_00_1_76543210_0_00000000_0_0
101_03_1_13579BDF_0_00000000_0_1
130_13_0_F1E2D3C4_2_00E2D300_6_2
000_00_0_0BADF00D_3_0BADF00D_F_3
231_12_0_24681357_1_00006800_2_0
100_10_0_9E8D7C6B_0_9E8D7C00_E_0
023_13_0_3C4B5A69_0_005A6900_6_0
011_30_0_778899AA_0_AA000000_8_0
123_23_0_FEDCBA98_0_00BA0000_4_2
200_20_1_10203040_2_00000000_0_0
000_00_0_FFFFFFFF_0_FFFFFFFF_F_1

// File: filelist.f
+incdir+include
design/idma_lite_pkg.sv
design/idma_lite_byte_fifo.sv
design/idma_lite_byte_buffer.sv
design/idma_lite_read_aligner.sv
design/idma_lite_write_assembler.sv
design/idma_axi_lite_transport_layer.sv
test/tb_idma_lite_transport.sv

// File: run_sim.sh
#!/bin/sh
# build the transport layer testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tb_idma_lite_transport -o tb_sim || exit 1

out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -q "Test completed successfully" && echo "PASS" || { echo "FAIL"; exit 1; }
